// File: cpu_top.f
+incdir+common
common/cpu_pkg.sv
design/cpu_fetch.sv
design/cpu_regfile.sv
pipeline/cpu_pipeline.sv
pipeline/cpu_hazard.sv
execute/cpu_execute.sv
design/cpu_top.sv
verification/cpu_props.sv
verification/cpu_tb.sv

// File: Makefile
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f cpu_top.f --top-module cpu_tb -o cpu_tb

run: build
	./obj_dir/cpu_tb | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f cpu_top.f --top-module cpu_tb

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

// File: verification/cpu_tb.sv
`include "cpu_defs.svh"

module cpu_tb;

timeunit 1ns;
timeprecision 100ps;

localparam int PROG_LEN = 35;
localparam int ROWS = 19;
localparam int CYCLE_LIMIT = 4 * PROG_LEN + 200;

logic CLK = 1'b0;
logic RSTb;
logic run = 1'b0;
logic [`CPU_ADDRESS_BITS-1:0] imem_address;
logic [`CPU_BITS-1:0] imem_data;
logic wb_valid;
logic [`CPU_REGISTER_BITS-1:0] wb_reg;
logic [`CPU_BITS-1:0] wb_data;
logic [`CPU_ADDRESS_BITS-1:0] wb_pc;

logic [`CPU_BITS-1:0] program_mem [0:PROG_LEN-1];
logic [`CPU_REGISTER_BITS-1:0] exp_reg [0:ROWS-1];
logic [`CPU_BITS-1:0] exp_data [0:ROWS-1];
logic [`CPU_ADDRESS_BITS-1:0] exp_pc [0:ROWS-1];

logic random_run = 1'b0;	// Second pass drops run at random
logic run_enable = 1'b0;
int cycle_count = 0;
int rows_loaded = 0;

cpu_top cpu_top_i (
	.CLK          (CLK),
	.RSTb         (RSTb),
	.run          (run),
	.imem_address (imem_address),
	.imem_data    (imem_data),
	.wb_valid     (wb_valid),
	.wb_reg       (wb_reg),
	.wb_data      (wb_data),
	.wb_pc        (wb_pc)
);

always #20 CLK = ~CLK;

// Asynchronous instruction read with NOP past the end of the program
assign imem_data = (imem_address < PROG_LEN) ? program_mem[imem_address] : `CPU_NOP;

always @(posedge CLK) begin
	if (random_run)
		run <= ($urandom % 4) != 0;
	else
		run <= run_enable;
end

always @(posedge CLK) begin
	cycle_count <= cycle_count + 1;
	if (cycle_count >= CYCLE_LIMIT) begin
		$display("timeout: write-backs did not complete within %0d cycles", CYCLE_LIMIT);
		$display("TB FAILED");
		$fatal(1, "simulation stopped after timeout");
	end
end

function automatic logic [`CPU_BITS-1:0] alu_rr(input cpu_pkg::alu_op_t op,
		input logic [3:0] d, input logic [3:0] s);
	return {cpu_pkg::OP_ALU_RR, op, d, s};
endfunction

function automatic logic [`CPU_BITS-1:0] alu_ri(input cpu_pkg::alu_op_t op,
		input logic [3:0] d, input logic [3:0] lo);
	return {cpu_pkg::OP_ALU_RI, op, d, lo};
endfunction

function automatic logic [`CPU_BITS-1:0] prefix(input logic [11:0] hi);
	return {cpu_pkg::OP_IMM, hi};
endfunction

function automatic logic [`CPU_BITS-1:0] branch(input cpu_pkg::cond_t c, input logic [3:0] lo);
	return {cpu_pkg::OP_BRANCH, c, 4'd0, lo};
endfunction

task automatic add_row(input logic [3:0] r, input logic [15:0] d, input logic [15:0] a);
	exp_reg[rows_loaded] = r;
	exp_data[rows_loaded] = d;
	exp_pc[rows_loaded] = a;
	rows_loaded++;
endtask

task automatic load_program();
	program_mem[0] = alu_ri(cpu_pkg::ALU_MOV, 1, 5);
	program_mem[1] = alu_ri(cpu_pkg::ALU_MOV, 2, 3);
	program_mem[2] = prefix(12'h123);
	program_mem[3] = alu_ri(cpu_pkg::ALU_MOV, 3, 4);	// r3 = 0x1234
	program_mem[4] = alu_rr(cpu_pkg::ALU_ADD, 1, 2);
	program_mem[5] = alu_rr(cpu_pkg::ALU_SUB, 3, 1);	// Two-cycle stall
	program_mem[6] = alu_ri(cpu_pkg::ALU_AND, 3, 4'hF);
	program_mem[7] = alu_ri(cpu_pkg::ALU_OR, 2, 4'h8);
	program_mem[8] = alu_rr(cpu_pkg::ALU_XOR, 2, 3);
	program_mem[9] = alu_rr(cpu_pkg::ALU_MOV, 4, 2);
	program_mem[10] = alu_ri(cpu_pkg::ALU_ADD, 5, 9);
	program_mem[11] = alu_rr(cpu_pkg::ALU_SUB, 4, 4);	// Zero result sets Z
	program_mem[12] = branch(cpu_pkg::COND_ZERO, 15);	// Taken
	program_mem[13] = alu_ri(cpu_pkg::ALU_MOV, 6, 1);	// Skipped
	program_mem[14] = alu_ri(cpu_pkg::ALU_MOV, 7, 1);	// Skipped
	program_mem[15] = alu_ri(cpu_pkg::ALU_MOV, 8, 2);
	program_mem[16] = branch(cpu_pkg::COND_ZERO, 0);	// Not taken
	program_mem[17] = alu_ri(cpu_pkg::ALU_ADD, 8, 4'hE);
	program_mem[18] = alu_ri(cpu_pkg::ALU_SUB, 9, 0);
	program_mem[19] = branch(cpu_pkg::COND_NONZERO, 0);	// Not taken
	program_mem[20] = alu_ri(cpu_pkg::ALU_XOR, 9, 5);
	program_mem[21] = prefix(12'h001);
	program_mem[22] = branch(cpu_pkg::COND_NONZERO, 8);	// To 0x18
	program_mem[23] = alu_ri(cpu_pkg::ALU_MOV, 10, 1);
	program_mem[24] = prefix(12'h001);
	program_mem[25] = branch(cpu_pkg::COND_ALWAYS, 4'hC);	// To 0x1C
	program_mem[26] = alu_ri(cpu_pkg::ALU_MOV, 11, 1);
	program_mem[27] = alu_ri(cpu_pkg::ALU_MOV, 12, 1);
	program_mem[28] = alu_rr(cpu_pkg::ALU_ADD, 13, 1);
	program_mem[29] = prefix(12'hFFF);
	program_mem[30] = alu_ri(cpu_pkg::ALU_ADD, 13, 4'hF);	// Adds 0xFFFF and wraps
	program_mem[31] = alu_ri(cpu_pkg::ALU_MOV, 14, 4'hA);	// Prefix already used
	program_mem[32] = alu_rr(cpu_pkg::ALU_MOV, 15, 13);
	program_mem[33] = prefix(12'h002);
	program_mem[34] = branch(cpu_pkg::COND_ALWAYS, 1);	// Park loop at 0x21
endtask

task automatic load_expected();
	add_row(1, 16'h0005, 0);
	add_row(2, 16'h0003, 1);
	add_row(3, 16'h1234, 3);
	add_row(1, 16'h0008, 4);
	add_row(3, 16'h122C, 5);
	add_row(3, 16'h000C, 6);
	add_row(2, 16'h000B, 7);
	add_row(2, 16'h0007, 8);
	add_row(4, 16'h0007, 9);
	add_row(5, 16'h0009, 10);
	add_row(4, 16'h0000, 11);
	add_row(8, 16'h0002, 15);
	add_row(8, 16'h0010, 17);
	add_row(9, 16'h0000, 18);
	add_row(9, 16'h0005, 20);
	add_row(13, 16'h0008, 28);
	add_row(13, 16'h0007, 30);
	add_row(14, 16'h000A, 31);
	add_row(15, 16'h0007, 32);
endtask

task automatic check_reg(input logic [`CPU_REGISTER_BITS-1:0] got,
		input logic [`CPU_REGISTER_BITS-1:0] exp, input int row);
	if (got !== exp) begin
		$display("MISMATCH at %0t: row %0d wrote r%0d, expected r%0d", $time, row, got, exp);
		$display("TB FAILED");
		$fatal(1, "write-back register mismatch");
	end
endtask

task automatic check_data(input logic [`CPU_BITS-1:0] got,
		input logic [`CPU_BITS-1:0] exp, input int row);
	if (got !== exp) begin
		$display("MISMATCH at %0t: row %0d data %h, expected %h", $time, row, got, exp);
		$display("TB FAILED");
		$fatal(1, "write-back data mismatch");
	end
endtask

task automatic check_pc(input logic [`CPU_ADDRESS_BITS-1:0] got,
		input logic [`CPU_ADDRESS_BITS-1:0] exp, input int row);
	if (got !== exp) begin
		$display("MISMATCH at %0t: row %0d address %h, expected %h", $time, row, got, exp);
		$display("TB FAILED");
		$fatal(1, "write-back address mismatch");
	end
endtask

task automatic run_pass(input logic drop_run);
	@(negedge CLK);
	random_run = 1'b0;
	run_enable = 1'b0;
	@(posedge CLK);
	RSTb <= 1'b0;
	repeat (4) @(posedge CLK);
	RSTb <= 1'b1;
	@(negedge CLK);
	random_run = drop_run;
	run_enable = 1'b1;
	for (int row = 0; row < ROWS; row++) begin
		@(negedge CLK);
		while (!wb_valid)
			@(negedge CLK);	// Outputs settled mid-cycle
		check_reg(wb_reg, exp_reg[row], row);
		check_data(wb_data, exp_data[row], row);
		check_pc(wb_pc, exp_pc[row], row);
	end
	// Program parks in a loop and nothing else may write back
	repeat (20) begin
		@(negedge CLK);
		if (wb_valid) begin
			$display("unexpected write-back of r%0d at address %h", wb_reg, wb_pc);
			$display("TB FAILED");
			$fatal(1, "extra write-back after the program end");
		end
	end
endtask

initial begin
	RSTb = 1'b0;
	void'($urandom(29));
	load_program();
	load_expected();
	run_pass(1'b0);
	run_pass(1'b1);	// Same sequence with run stalls
	$display("TB PASSED");
	$finish;
end

endmodule

// File: verification/cpu_props.sv
`include "cpu_defs.svh"

module cpu_props (
	input logic CLK,
	input logic RSTb,
	input logic run,
	input logic stall,
	input logic load_pc,
	input cpu_pkg::instruction_t pipeline_stage0,
	input cpu_pkg::instruction_t pipeline_stage1,
	input cpu_pkg::instruction_t pipeline_stage2,
	input cpu_pkg::instruction_t pipeline_stage4
);

timeunit 1ns;
timeprecision 100ps;

// Reset clears the last stage
reset_clears_wb: assert property (@(posedge CLK) !RSTb |=> pipeline_stage4 == `CPU_NOP)
	else $error("stage 4 not NOP after reset");

bubble_on_stall: assert property (@(posedge CLK) disable iff (!RSTb)
	(stall && run && !load_pc) |=> pipeline_stage2 == `CPU_NOP)
	else $error("no bubble in stage 2 after stall");

// Words behind a taken branch are dropped
flush_on_branch: assert property (@(posedge CLK) disable iff (!RSTb)
	load_pc |=> (pipeline_stage0 == `CPU_NOP && pipeline_stage1 == `CPU_NOP))
	else $error("stages 0 and 1 not flushed after branch");

endmodule

bind cpu_pipeline cpu_props cpu_props_i (.*);

// File: design/cpu_top.sv
`include "cpu_defs.svh"

module cpu_top (
	input  logic CLK,
	input  logic RSTb,
	input  logic run,
	output logic [`CPU_ADDRESS_BITS-1:0] imem_address,
	input  logic [`CPU_BITS-1:0] imem_data,
	output logic wb_valid,
	output logic [`CPU_REGISTER_BITS-1:0] wb_reg,
	output logic [`CPU_BITS-1:0] wb_data,
	output logic [`CPU_ADDRESS_BITS-1:0] wb_pc
);

logic stall;
logic load_pc;
logic [`CPU_ADDRESS_BITS-1:0] branch_target;

// Destination chain for hazard checks
logic [`CPU_REGISTER_BITS-1:0] hazard_reg0;
logic [`CPU_REGISTER_BITS-1:0] hazard_reg2;
logic [`CPU_REGISTER_BITS-1:0] hazard_reg3;

cpu_pkg::instruction_t pipeline_stage0;
cpu_pkg::instruction_t pipeline_stage1;
cpu_pkg::instruction_t pipeline_stage2;
cpu_pkg::instruction_t pipeline_stage4;

logic [`CPU_BITS-1:0] imm_word;	// Full immediate of stage 2
logic [`CPU_BITS-1:0] read_data_a;
logic [`CPU_BITS-1:0] read_data_b;

cpu_fetch cpu_fetch_i (
	.CLK           (CLK),
	.RSTb          (RSTb),
	.run           (run),
	.stall         (stall),
	.load_pc       (load_pc),
	.branch_target (branch_target),
	.imem_address  (imem_address)
);

cpu_pipeline cpu_pipeline_i (
	.CLK             (CLK),
	.RSTb            (RSTb),
	.run             (run),
	.stall           (stall),
	.load_pc         (load_pc),
	.memory_in       (imem_data),
	.memory_address  (imem_address),
	.hazard_reg0     (hazard_reg0),
	.pipeline_stage0 (pipeline_stage0),
	.pipeline_stage1 (pipeline_stage1),
	.pipeline_stage2 (pipeline_stage2),
	.pipeline_stage3 (),
	.pipeline_stage4 (pipeline_stage4),
	.pc_stage2       (),
	.pc_stage4       (wb_pc),
	.hazard_reg1     (),
	.hazard_reg2     (hazard_reg2),
	.hazard_reg3     (hazard_reg3),
	.imm_word        (imm_word)
);

cpu_hazard cpu_hazard_i (
	.pipeline_stage0 (pipeline_stage0),
	.pipeline_stage1 (pipeline_stage1),
	.hazard_reg2     (hazard_reg2),
	.hazard_reg3     (hazard_reg3),
	.hazard_reg0     (hazard_reg0),
	.stall           (stall)
);

// Operands are read with the stage 1 fields
cpu_regfile cpu_regfile_i (
	.CLK          (CLK),
	.RSTb         (RSTb),
	.write_enable (wb_valid),
	.write_reg    (wb_reg),
	.write_data   (wb_data),
	.read_reg_a   (pipeline_stage1.rr.dest),
	.read_reg_b   (pipeline_stage1.rr.src),
	.read_data_a  (read_data_a),
	.read_data_b  (read_data_b)
);

cpu_execute cpu_execute_i (
	.CLK             (CLK),
	.RSTb            (RSTb),
	.run             (run),
	.pipeline_stage2 (pipeline_stage2),
	.pipeline_stage4 (pipeline_stage4),
	.imm_word        (imm_word),
	.read_data_a     (read_data_a),
	.read_data_b     (read_data_b),
	.load_pc         (load_pc),
	.branch_target   (branch_target),
	.write_enable    (wb_valid),
	.write_reg       (wb_reg),
	.write_data      (wb_data)
);

endmodule

// File: execute/cpu_execute.sv
`include "cpu_defs.svh"

module cpu_execute (
	input  logic CLK,
	input  logic RSTb,
	input  logic run,
	input  cpu_pkg::instruction_t pipeline_stage2,
	input  cpu_pkg::instruction_t pipeline_stage4,
	input  logic [`CPU_BITS-1:0] imm_word,
	input  logic [`CPU_BITS-1:0] read_data_a,
	input  logic [`CPU_BITS-1:0] read_data_b,
	output logic load_pc,
	output logic [`CPU_ADDRESS_BITS-1:0] branch_target,
	output logic write_enable,
	output logic [`CPU_REGISTER_BITS-1:0] write_reg,
	output logic [`CPU_BITS-1:0] write_data
);

logic [`CPU_BITS-1:0] operand_a;
logic [`CPU_BITS-1:0] operand_b;
logic [`CPU_BITS-1:0] alu_b;
logic [`CPU_BITS-1:0] alu_result;
logic [`CPU_BITS-1:0] result_stage3;
logic [`CPU_BITS-1:0] result_stage4;
logic z_flag;
logic alu_stage2;
logic alu_stage4;
logic taken;

// Operands follow stage 1 into stage 2, results follow to stage 4
always_ff @(posedge CLK) begin
	if (run) begin
		operand_a <= read_data_a;
		operand_b <= read_data_b;
		result_stage3 <= alu_result;
		result_stage4 <= result_stage3;
	end
end

assign alu_stage2 = pipeline_stage2.rr.opcode == cpu_pkg::OP_ALU_RR ||
		pipeline_stage2.rr.opcode == cpu_pkg::OP_ALU_RI;
assign alu_b = (pipeline_stage2.rr.opcode == cpu_pkg::OP_ALU_RR) ? operand_b : imm_word;

always_comb begin
	case (pipeline_stage2.rr.alu_op)
		cpu_pkg::ALU_ADD: alu_result = operand_a + alu_b;
		cpu_pkg::ALU_SUB: alu_result = operand_a - alu_b;
		cpu_pkg::ALU_AND: alu_result = operand_a & alu_b;
		cpu_pkg::ALU_OR:  alu_result = operand_a | alu_b;
		cpu_pkg::ALU_XOR: alu_result = operand_a ^ alu_b;
		default:          alu_result = alu_b;	// MOV
	endcase
end

// Z is only set by ALU words, bubbles leave it alone
always_ff @(posedge CLK) begin
	if (!RSTb)
		z_flag <= 1'b0;
	else if (run && alu_stage2)
		z_flag <= (alu_result == '0);
end

always_comb begin
	taken = 1'b0;
	if (pipeline_stage2.br.opcode == cpu_pkg::OP_BRANCH) begin
		case (pipeline_stage2.br.cond)
			cpu_pkg::COND_ALWAYS:  taken = 1'b1;
			cpu_pkg::COND_ZERO:    taken = z_flag;
			cpu_pkg::COND_NONZERO: taken = !z_flag;
			default:               taken = 1'b0;
		endcase
	end
end

assign load_pc = run && taken;
assign branch_target = imm_word;	// Absolute target

// Write port from stage 4, once per word
assign alu_stage4 = pipeline_stage4.rr.opcode == cpu_pkg::OP_ALU_RR ||
		pipeline_stage4.rr.opcode == cpu_pkg::OP_ALU_RI;
assign write_enable = run && alu_stage4 && (pipeline_stage4.rr.dest != '0);
assign write_reg = pipeline_stage4.rr.dest;
assign write_data = result_stage4;

endmodule

// File: pipeline/cpu_hazard.sv
`include "cpu_defs.svh"

module cpu_hazard (
	input  cpu_pkg::instruction_t pipeline_stage0,
	input  cpu_pkg::instruction_t pipeline_stage1,
	input  logic [`CPU_REGISTER_BITS-1:0] hazard_reg2,
	input  logic [`CPU_REGISTER_BITS-1:0] hazard_reg3,
	output logic [`CPU_REGISTER_BITS-1:0] hazard_reg0,
	output logic stall
);

logic [`CPU_REGISTER_BITS-1:0] source_a;	// Destination used as left operand
logic [`CPU_REGISTER_BITS-1:0] source_b;
logic conflict_a;
logic conflict_b;

// Only ALU words write a register
always_comb begin
	hazard_reg0 = '0;
	if (pipeline_stage0.rr.opcode == cpu_pkg::OP_ALU_RR ||
		pipeline_stage0.rr.opcode == cpu_pkg::OP_ALU_RI)
		hazard_reg0 = pipeline_stage0.rr.dest;
end

// Registers read by the word in stage 1
always_comb begin
	source_a = '0;
	source_b = '0;
	case (pipeline_stage1.rr.opcode)
		cpu_pkg::OP_ALU_RR: begin
			if (pipeline_stage1.rr.alu_op != cpu_pkg::ALU_MOV)
				source_a = pipeline_stage1.rr.dest;
			source_b = pipeline_stage1.rr.src;
		end
		cpu_pkg::OP_ALU_RI: begin
			if (pipeline_stage1.ri.alu_op != cpu_pkg::ALU_MOV)
				source_a = pipeline_stage1.ri.dest;
		end
		default: ;
	endcase
end

// Stage 4 is covered by the register file write-through
assign conflict_a = (source_a != '0) && (source_a == hazard_reg2 || source_a == hazard_reg3);
assign conflict_b = (source_b != '0) && (source_b == hazard_reg2 || source_b == hazard_reg3);
assign stall = conflict_a || conflict_b;

endmodule

// File: pipeline/cpu_pipeline.sv
`include "cpu_defs.svh"

module cpu_pipeline (
	input  logic CLK,
	input  logic RSTb,
	input  logic run,
	input  logic stall,
	input  logic load_pc,
	input  logic [`CPU_BITS-1:0] memory_in,
	input  logic [`CPU_ADDRESS_BITS-1:0] memory_address,
	input  logic [`CPU_REGISTER_BITS-1:0] hazard_reg0,
	output cpu_pkg::instruction_t pipeline_stage0,
	output cpu_pkg::instruction_t pipeline_stage1,
	output cpu_pkg::instruction_t pipeline_stage2,
	output cpu_pkg::instruction_t pipeline_stage3,
	output cpu_pkg::instruction_t pipeline_stage4,
	output logic [`CPU_ADDRESS_BITS-1:0] pc_stage2,
	output logic [`CPU_ADDRESS_BITS-1:0] pc_stage4,
	output logic [`CPU_REGISTER_BITS-1:0] hazard_reg1,
	output logic [`CPU_REGISTER_BITS-1:0] hazard_reg2,
	output logic [`CPU_REGISTER_BITS-1:0] hazard_reg3,
	output logic [`CPU_BITS-1:0] imm_word
);

logic [`CPU_ADDRESS_BITS-1:0] pc_stage0;
logic [`CPU_ADDRESS_BITS-1:0] pc_stage1;
logic [`CPU_ADDRESS_BITS-1:0] pc_stage3;

logic [11:0] imm_r;	// Prefix from the last IMM word

// Word, address and destination move together
always_ff @(posedge CLK) begin
	if (!RSTb) begin
		pipeline_stage0 <= `CPU_NOP;
		pipeline_stage1 <= `CPU_NOP;
		pipeline_stage2 <= `CPU_NOP;
		pipeline_stage3 <= `CPU_NOP;
		pipeline_stage4 <= `CPU_NOP;
		pc_stage0 <= '0;
		pc_stage1 <= '0;
		pc_stage2 <= '0;
		pc_stage3 <= '0;
		pc_stage4 <= '0;
		hazard_reg1 <= '0;
		hazard_reg2 <= '0;
		hazard_reg3 <= '0;
	end else if (run) begin
		// Memory and write-back stages always drain
		pipeline_stage3 <= pipeline_stage2;
		pipeline_stage4 <= pipeline_stage3;
		pc_stage3 <= pc_stage2;
		pc_stage4 <= pc_stage3;
		hazard_reg3 <= hazard_reg2;

		if (load_pc) begin
			// Branch taken, drop the words fetched behind it
			pipeline_stage0 <= `CPU_NOP;
			pipeline_stage1 <= `CPU_NOP;
			pipeline_stage2 <= `CPU_NOP;
			hazard_reg1 <= '0;
			hazard_reg2 <= '0;
		end else if (stall) begin
			pipeline_stage2 <= `CPU_NOP;	// Bubble, stages 0 and 1 hold
			hazard_reg2 <= '0;
		end else begin
			pipeline_stage0 <= memory_in;
			pipeline_stage1 <= pipeline_stage0;
			pipeline_stage2 <= pipeline_stage1;
			pc_stage0 <= memory_address;
			pc_stage1 <= pc_stage0;
			pc_stage2 <= pc_stage1;
			hazard_reg1 <= hazard_reg0;
			hazard_reg2 <= hazard_reg1;
		end
	end
end

// Immediate prefix, consumed by the first real word after the IMM
always_ff @(posedge CLK) begin
	if (!RSTb) begin
		imm_r <= '0;
	end else if (run) begin
		if (load_pc) begin
			imm_r <= '0;
		end else if (!stall) begin
			if (pipeline_stage1.imm.opcode == cpu_pkg::OP_IMM)
				imm_r <= pipeline_stage1.imm.imm_hi;
			else if (pipeline_stage1.imm.opcode != cpu_pkg::OP_NOP)
				imm_r <= '0;	// Used up by this word
		end
	end
end

// Only meaningful for a word that enters stage 2
always_ff @(posedge CLK) begin
	if (run)
		imm_word <= {imm_r, pipeline_stage1.ri.imm_lo};
end

endmodule

// File: design/cpu_regfile.sv
`include "cpu_defs.svh"

module cpu_regfile (
	input  logic CLK,
	input  logic RSTb,
	input  logic write_enable,
	input  logic [`CPU_REGISTER_BITS-1:0] write_reg,
	input  logic [`CPU_BITS-1:0] write_data,
	input  logic [`CPU_REGISTER_BITS-1:0] read_reg_a,
	input  logic [`CPU_REGISTER_BITS-1:0] read_reg_b,
	output logic [`CPU_BITS-1:0] read_data_a,
	output logic [`CPU_BITS-1:0] read_data_b
);

logic [`CPU_BITS-1:0] regs [1:(1 << `CPU_REGISTER_BITS) - 1];	// No storage for r0

always_ff @(posedge CLK) begin
	if (!RSTb) begin
		for (int i = 1; i < (1 << `CPU_REGISTER_BITS); i++) begin
			regs[i] <= '0;
		end
	end else if (write_enable && write_reg != '0) begin
		regs[write_reg] <= write_data;
	end
end

// Write-through, so stage 1 sees what stage 4 writes this cycle
function automatic logic [`CPU_BITS-1:0] read_port(input logic [`CPU_REGISTER_BITS-1:0] r);
	if (r == '0)
		return '0;
	if (write_enable && write_reg == r)
		return write_data;
	return regs[r];
endfunction

always_comb begin
	read_data_a = read_port(read_reg_a);
	read_data_b = read_port(read_reg_b);
end

endmodule

// File: design/cpu_fetch.sv
`include "cpu_defs.svh"

module cpu_fetch (
	input  logic CLK,
	input  logic RSTb,
	input  logic run,
	input  logic stall,
	input  logic load_pc,
	input  logic [`CPU_ADDRESS_BITS-1:0] branch_target,
	output logic [`CPU_ADDRESS_BITS-1:0] imem_address
);

logic [`CPU_ADDRESS_BITS-1:0] pc;

// Instruction read is asynchronous, so holding the PC is enough on a stall
always_ff @(posedge CLK) begin
	if (!RSTb) begin
		pc <= '0;
	end else if (load_pc) begin
		pc <= branch_target;	// Taken branch in execute
	end else if (run && !stall) begin
		pc <= pc + 1'b1;
	end
end

assign imem_address = pc;

endmodule

// File: common/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

typedef enum logic [3:0] {
	OP_NOP    = 4'd0,
	OP_IMM    = 4'd1,	// Upper 12 bits for the next word
	OP_ALU_RR = 4'd2,
	OP_ALU_RI = 4'd3,
	OP_BRANCH = 4'd4	// Absolute, target is the full immediate
} opcode_t;

typedef enum logic [3:0] {
	ALU_ADD = 4'd0,
	ALU_SUB = 4'd1,
	ALU_AND = 4'd2,
	ALU_OR  = 4'd3,
	ALU_XOR = 4'd4,
	ALU_MOV = 4'd5
} alu_op_t;

typedef enum logic [3:0] {
	COND_ALWAYS  = 4'd0,
	COND_ZERO    = 4'd1,
	COND_NONZERO = 4'd2
} cond_t;

// Register-register form
typedef struct packed {
	opcode_t opcode;
	alu_op_t alu_op;
	logic [`CPU_REGISTER_BITS-1:0] dest;
	logic [`CPU_REGISTER_BITS-1:0] src;
} rr_t;

typedef struct packed {
	opcode_t opcode;
	alu_op_t alu_op;
	logic [`CPU_REGISTER_BITS-1:0] dest;
	logic [3:0] imm_lo;	// Low nibble, imm_hi comes from the prefix
} ri_t;

typedef struct packed {
	opcode_t opcode;
	logic [11:0] imm_hi;
} imm_t;

typedef struct packed {
	opcode_t opcode;
	cond_t cond;
	logic [3:0] unused;
	logic [3:0] imm_lo;
} br_t;

// One word, decoded by its opcode
typedef union packed {
	rr_t rr;
	ri_t ri;
	imm_t imm;
	br_t br;
} instruction_t;

endpackage

// File: common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Instruction and data word width
`define CPU_BITS 16

`define CPU_ADDRESS_BITS 16	// Instruction address width

// Sixteen registers, r0 reads zero
`define CPU_REGISTER_BITS 4

// Opcode 0 with all fields clear
`define CPU_NOP {`CPU_BITS{1'b0}}

`endif
